// File: dv/sprite_stimulus.txt
# kind 1: sel index data | kind 2: addr word | kind 0: end of file
# kind 3: frame nfetch addr... npix (x value)...  frame, counts and x decimal, rest hex
1 1 02 0600040A00010080
1 1 05 0201020E00020081
1 1 07 0A00021E00030000
1 1 09 0414022800040080
1 1 0C 0202056400050080
1 2 01 11
1 2 02 12
1 2 03 13
1 2 04 14
1 2 05 15
1 2 06 16
1 2 07 17
1 2 08 18
1 2 09 19
1 2 0A 1A
1 2 0B 1B
1 2 0C 1C
1 2 0D 1D
1 2 0E 1E
1 2 0F 1F
1 2 1C 3C
1 2 1D 3D
2 100 1234
2 101 5060
2 102 7007
2 103 89AB
2 104 CDEF
2 105 1111
2 200 0C0D
2 500 2345
2 501 6666
3 1 2 100 101 0
3 0 3 102 103 200 6 10 51 11 52 12 53 13 54 14 55 16 56
3 0 4 104 105 500 501 6 10 57 13 57 14 58 15 7C 16 5A 17 7D
3 0 0 12 10 5C 11 5D 12 5E 13 5F 14 51 15 51 16 51 17 51 356 52 357 53 358 54 359 55
3 1 2 100 101 0
3 0 3 102 103 200 6 10 51 11 52 12 53 13 54 14 55 16 56
0

// File: dv/sprite_unit_chk.sv
`timescale 1ns/1ns

module sprite_unit_chk
	import spr_mem_pkg::*;
(
	input logic      clk,
	input logic      arst_n,
	input logic      mem_req,
	input mem_addr_t mem_addr,
	input logic      mem_ack,
	input logic      pix_stb
);

	// --------------------
	// memory handshake
	// --------------------
	// address held for the whole request
	a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_req && $past(mem_req)) |-> (mem_addr == $past(mem_addr)))
		else $error("mem_addr changed while mem_req was high");

	// new request only once the previous ack is gone
	a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
		(!mem_req && mem_ack) |=> !mem_req)
		else $error("mem_req rose while mem_ack was high");

	// --------------------
	// pixel strobe
	// --------------------
	a_stb_gap: assert property (@(posedge clk) disable iff (!arst_n)
		pix_stb |=> !pix_stb)
		else $error("pix_stb high on two adjacent cycles");

endmodule

bind sprite_unit sprite_unit_chk i_sprite_unit_chk (
	.clk      (clk),
	.arst_n   (arst_n),
	.mem_req  (mem_req),
	.mem_addr (mem_addr),
	.mem_ack  (mem_ack),
	.pix_stb  (pix_stb)
);

// File: dv/sprite_unit_tb.sv
`timescale 1ns/1ns

module sprite_unit_tb
	import spr_geom_pkg::*, spr_mem_pkg::*;
();

	localparam int line_period = 1600;   // clocks per line
	localparam int run_limit = 12000;    // whole run, in clocks

	logic      clk, arst_n;
	logic      line_start, frame_start;
	logic      tbl_we;
	tbl_wr_t   tbl_wr;
	logic      mem_req, mem_ack;
	mem_addr_t mem_addr;
	mem_word_t mem_data;
	logic      busy, pix_stb;
	spr_pix_t  pix;

	mem_word_t   mem_img [mem_addr_t];  // sparse memory image
	mem_addr_t   fetch_q [$];           // expected fetches of the running line
	spr_pix_t    exp_pix [h_pixels];    // expected stream of the running line
	logic [15:0] lfsr;

	sprite_unit i_sprite_unit (.*);

	// --------------------
	// clock and watchdog
	// --------------------
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		for (int i = 0; i < run_limit; i++)
			@(posedge clk);
		$display("simulation ran out of time");
		abort_run();
	end

	// --------------------
	// checks
	// --------------------
	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_pix(input string name, input spr_pix_t got, input spr_pix_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);  // one step per bit
	endtask

	// --------------------
	// memory responder
	// --------------------
	initial
	begin
		int   rsp_st, rsp_cnt, rsp_wait;
		logic b;
		logic [2:0] v;
		rsp_st = 0;
		rsp_cnt = 0;
		rsp_wait = 0;
		forever
		begin
			@(negedge clk);
			case (rsp_st)
				0:
					if (mem_req && arst_n)
					begin
						if (fetch_q.size() == 0)
						begin
							$display("fetch at %h while no fetch was expected", mem_addr);
							abort_run();
						end
						check_addr("mem_addr", mem_addr, fetch_q.pop_front());
						if (!mem_img.exists(mem_addr))
						begin
							$display("fetch at %h outside the memory image", mem_addr);
							abort_run();
						end
						for (int i = 0; i < 3; i++)
						begin
							take_bit(b);
							v[i] = b;
						end
						rsp_cnt = 1 + (v % 7);  // 1 to 7 cycles
						rsp_st = 1;
					end
				1:
				begin
					rsp_cnt--;
					if (rsp_cnt == 0)
					begin
						mem_data = mem_img[mem_addr];
						mem_ack = 1'b1;
						rsp_wait = 0;
						rsp_st = 2;
					end
				end
				default:
					if (!mem_req)
					begin
						mem_ack = 1'b0;  // closes the four phases
						rsp_st = 0;
					end
					else
					begin
						rsp_wait++;
						if (rsp_wait > 50)
						begin
							$display("mem_req stayed high after mem_ack");
							abort_run();
						end
					end
			endcase
		end
	end

	// --------------------
	// stimulus
	// --------------------
	task automatic host_write(input logic [1:0] sel, input logic [5:0] idx,
		input logic [63:0] data);
		tbl_wr = '{sel: sel, index: idx, data: data};
		tbl_we = 1'b1;
		@(negedge clk);
		tbl_we = 1'b0;
	endtask

	// one line period, stream compared against exp_pix
	task automatic run_line(input logic fr);
		int n;
		n = 0;
		line_start = 1'b1;
		frame_start = fr;
		for (int c = 0; c < line_period; c++)
		begin
			@(negedge clk);
			if (c == 0)
			begin
				line_start = 1'b0;
				frame_start = 1'b0;
				check_bit("busy", busy, 1'b1);
			end
			if (pix_stb)
			begin
				if (n >= h_pixels)
				begin
					$display("more than %0d pixel strobes on one line", h_pixels);
					abort_run();
				end
				check_pix($sformatf("pix[%0d]", n), pix, exp_pix[n]);
				n++;
			end
		end
		if (n != h_pixels)
		begin
			$display("line stream ended after %0d pixels", n);
			abort_run();
		end
		if (fetch_q.size() != 0)
		begin
			$display("%0d expected fetches never happened", fetch_q.size());
			abort_run();
		end
		check_bit("busy", busy, 1'b0);  // line finished before the next start
	endtask

	initial
	begin
		int          fd, r, kind, fr, nf, np, x;
		logic [63:0] h1, h2, h3;
		string       hdr;
		logic        done;
		arst_n = 1'b0;
		line_start = 1'b0;
		frame_start = 1'b0;
		tbl_we = 1'b0;
		tbl_wr = '0;
		mem_ack = 1'b0;
		mem_data = '0;
		lfsr = 16'd47622;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("mem_req", mem_req, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("pix_stb", pix_stb, 1'b0);

		fd = $fopen("dv/sprite_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file");
			abort_run();
		end
		r = $fgets(hdr, fd);  // two column description lines
		r = $fgets(hdr, fd);
		done = 1'b0;
		while (!done)
		begin
			r = $fscanf(fd, "%d", kind);
			if (r != 1)
			begin
				$display("stimulus file ended without an end record");
				abort_run();
			end
			case (kind)
				0: done = 1'b1;
				1:
				begin
					r = $fscanf(fd, "%h %h %h", h1, h2, h3);
					host_write(h1[1:0], h2[5:0], h3);
				end
				2:
				begin
					r = $fscanf(fd, "%h %h", h1, h2);
					mem_img[mem_addr_t'(h1)] = mem_word_t'(h2);
				end
				3:
				begin
					r = $fscanf(fd, "%d %d", fr, nf);
					for (int i = 0; i < nf; i++)
					begin
						r = $fscanf(fd, "%h", h1);
						fetch_q.push_back(mem_addr_t'(h1));
					end
					r = $fscanf(fd, "%d", np);
					for (int i = 0; i < h_pixels; i++)
						exp_pix[i] = pix_blank;  // background elsewhere
					for (int i = 0; i < np; i++)
					begin
						r = $fscanf(fd, "%d %h", x, h1);
						exp_pix[x] = spr_pix_t'(h1[6:0]);
					end
					run_line(fr[0]);
				end
				default:
				begin
					$display("unknown record kind %0d in the stimulus file", kind);
					abort_run();
				end
			endcase
		end
		$fclose(fd);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the sprite unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sprite_unit.f --top-module sprite_unit_tb -o sim_sprite_unit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_sprite_unit 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1

// File: source/line_buffers.sv
`timescale 1ns/1ns

module line_buffers
	import spr_geom_pkg::*, spr_mem_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       line_start,
	// engine writes, back half
	input  logic       buf_we,
	input  spr_coord_t buf_x,
	input  spr_pix_t   buf_pix,
	// pixel stream, front half
	output spr_pix_t   pix,
	output logic       pix_stb
);

	spr_pix_t lbuf [2][lbuf_depth];  // ping-pong halves

	logic                 side;      // front half, back is ~side
	logic                 rd_run;    // readout in progress
	spr_coord_t           rd_addr;
	logic [pix_cnt_w-1:0] div_cnt;   // pixel pacing
	logic                 wr_ok;

	// later sprites simply overwrite, transparent pixels leave what is there
	assign wr_ok = buf_we && buf_pix.opaque && (buf_x < h_pixels);

	// --------------------
	// readout
	// --------------------
	assign pix_stb = rd_run && (div_cnt == '0);
	assign pix = lbuf[side][rd_addr];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			side <= 1'b0;
			rd_run <= 1'b0;
			rd_addr <= '0;
			div_cnt <= '0;
			// both halves start blank so the first line shows background
			for (int s = 0; s < 2; s++)
				for (int i = 0; i < lbuf_depth; i++)
					lbuf[s][i] <= pix_blank;
		end
		else
		begin
			if (line_start)
			begin
				side <= ~side;  // rendered half goes to the front
				rd_run <= 1'b1;
				rd_addr <= '0;
				div_cnt <= '0;
			end
			else if (rd_run)
			begin
				div_cnt <= div_cnt + 1'b1;
				if (pix_stb)
					lbuf[side][rd_addr] <= pix_blank;  // clear as read
				if (div_cnt == pix_cnt_w'(pix_period - 1))
				begin
					if (rd_addr == spr_coord_t'(h_pixels - 1))
						rd_run <= 1'b0;  // whole line out
					else
						rd_addr <= rd_addr + 1'b1;
				end
			end
			// --------------------
			// engine side, never the half being read
			// --------------------
			if (wr_ok)
				lbuf[~side][buf_x] <= buf_pix;
		end
	end

endmodule

// File: source/spr_geom_pkg.sv
package spr_geom_pkg;

	// --------------------
	// raster geometry
	// --------------------
	localparam int h_pixels = 360;     // visible pixels per line
	localparam int v_lines = 288;      // visible lines per frame
	localparam int sprite_count = 32;  // descriptors walked per line

	typedef logic [4:0] spr_idx_t;     // sprite number
	typedef logic [8:0] spr_coord_t;   // x or y, 0..511

	// --------------------
	// sprite descriptor
	// --------------------
	// 64 bit word, msb first
	// [63:57] ysize  [56:48] ypos  [47:41] xsize  [40:32] xpos
	// [28:8] base  [7] active  [5:0] pal_bank
	typedef struct packed {
		logic [6:0]  ysize;     // height in lines
		spr_coord_t  ypos;      // first line
		logic [6:0]  xsize;     // width in words, four pixels each
		spr_coord_t  xpos;      // leftmost pixel
		logic [2:0]  spare_hi;
		logic [20:0] base;      // word address of row 0
		logic        active;
		logic        spare_lo;  // was the colour mode bit
		logic [5:0]  pal_bank;  // upper palette index bits
	} spr_desc_t;

	// --------------------
	// host table write
	// --------------------
	localparam logic [1:0] tbl_sel_desc = 2'd1;  // index picks a descriptor
	localparam logic [1:0] tbl_sel_pal = 2'd2;   // index picks a palette entry

	typedef struct packed {
		logic [1:0]  sel;
		logic [5:0]  index;
		logic [63:0] data;  // descriptor word or color in the low bits
	} tbl_wr_t;

endpackage

// File: source/spr_mem_pkg.sv
package spr_mem_pkg;

	// --------------------
	// external word memory
	// --------------------
	typedef logic [20:0] mem_addr_t;  // 2M words of 16 bits
	typedef logic [15:0] mem_word_t;  // leftmost pixel in [15:12]
	typedef logic [13:0] row_offs_t;  // 128 words x 128 lines max

	localparam int nib_per_word = 4;  // pixels per memory word

	// palette
	localparam int color_w = 6;
	localparam int pal_entries = 64;
	localparam int pal_idx_w = 10;    // pal_bank then nibble

	// pixel as stored in the line buffer
	typedef struct packed {
		logic               opaque;
		logic [color_w-1:0] color;
	} spr_pix_t;

	localparam spr_pix_t pix_blank = '0;  // transparent, black

	// line buffer readout
	localparam int lbuf_depth = spr_geom_pkg::h_pixels;
	localparam int pix_period = 4;       // clocks per output pixel
	localparam int pix_cnt_w = $clog2(pix_period);

endpackage

// File: source/sprite_engine.sv
`timescale 1ns/1ns

module sprite_engine
	import spr_geom_pkg::*, spr_mem_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 line_start,
	input  logic                 frame_start,
	output logic                 busy,
	// tables
	output spr_idx_t             desc_idx,
	input  spr_desc_t            desc,
	output logic [pal_idx_w-1:0] pal_idx,
	input  logic [color_w-1:0]   pal_color,
	output logic                 offs_we,
	output spr_idx_t             offs_idx,
	output row_offs_t            offs_wd,
	input  row_offs_t            offs_rd,
	// memory port, four phase
	output logic                 mem_req,
	output mem_addr_t            mem_addr,
	input  logic                 mem_ack,
	input  mem_word_t            mem_data,
	// line buffer write
	output logic                 buf_we,
	output spr_coord_t           buf_x,
	output spr_pix_t             buf_pix
);

	typedef enum logic [2:0] {
		st_idle,   // line done, wait for line_start
		st_desc,   // test sprite sp_num against line_y
		st_req,    // word handshake
		st_pix,    // four pixel cycles
		st_next,   // offset write, step sprite
		st_drain   // line aborted with a request open
	} eng_st_t;

	eng_st_t    state;
	spr_idx_t   sp_num;        // sprite being processed
	spr_coord_t line_y;        // line being rendered
	row_offs_t  offs;          // running word offset of the sprite
	logic [6:0] wcnt;          // words left in the row
	logic [9:0] x_cur;         // bit 9 marks a run past 511
	logic [$clog2(nib_per_word)-1:0] nib_cnt;
	mem_word_t  word_sr;       // fetched word, current pixel on top

	logic       hit, first_line, last_nib;
	logic       req_go, data_go, pix_go;
	logic [9:0] y_end;

	// --------------------
	// sprite selection
	// --------------------
	assign y_end = {1'b0, desc.ypos} + {3'b0, desc.ysize};
	assign hit = desc.active && (line_y >= desc.ypos) && ({1'b0, line_y} < y_end)
		&& (line_y < v_lines);
	assign first_line = (line_y == desc.ypos);  // row offset restarts here

	assign last_nib = (nib_cnt == ($clog2(nib_per_word))'(nib_per_word - 1));

	// one new request only after the previous ack is gone
	assign req_go = (state == st_req) && !mem_req && !mem_ack && !line_start;
	assign data_go = (state == st_req) && mem_req && mem_ack && !line_start;
	assign pix_go = (state == st_pix) && !line_start;

	assign busy = (state != st_idle);
	assign desc_idx = sp_num;
	assign offs_idx = sp_num;
	assign offs_wd = offs;   // valid while offs_we is high
	assign pal_idx = {desc.pal_bank, word_sr[15:12]};

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_idle;
			sp_num <= '0;
			line_y <= '0;
			offs <= '0;
			wcnt <= '0;
			x_cur <= '0;
			nib_cnt <= '0;
			mem_req <= 1'b0;
			buf_we <= 1'b0;
			offs_we <= 1'b0;
		end
		else
		begin
			buf_we <= pix_go && !x_cur[9];  // x past 511 never reaches the buffer
			offs_we <= 1'b0;                 // one cycle strobe
			if (line_start)
			begin
				// new line, also aborts a running one; stored offsets stay
				if (frame_start)
					line_y <= '0;
				else if (line_y < v_lines)
					line_y <= line_y + 1'b1;  // holds in blanking
				sp_num <= '0;
				state <= mem_req ? st_drain : st_desc;
			end
			else
			begin
				case (state)
					st_desc:
					begin
						if (hit)
						begin
							offs <= first_line ? '0 : offs_rd;
							wcnt <= desc.xsize;
							x_cur <= {1'b0, desc.xpos};
							if (desc.xsize == 7'd0)
							begin
								offs_we <= 1'b1;  // empty row, offset unchanged
								state <= st_next;
							end
							else
								state <= st_req;
						end
						else
							state <= st_next;
					end
					st_req:
					begin
						if (req_go)
							mem_req <= 1'b1;
						else if (data_go)
						begin
							mem_req <= 1'b0;  // data taken, release
							nib_cnt <= '0;
							state <= st_pix;
						end
					end
					st_pix:
					begin
						x_cur <= x_cur + 10'd1;
						nib_cnt <= nib_cnt + 1'b1;
						if (last_nib)
						begin
							offs <= offs + 1'b1;
							wcnt <= wcnt - 7'd1;
							if (wcnt == 7'd1)
							begin
								offs_we <= 1'b1;  // row done, save offset
								state <= st_next;
							end
							else
								state <= st_req;
						end
					end
					st_next:
					begin
						if (sp_num == spr_idx_t'(sprite_count - 1))
							state <= st_idle;
						else
						begin
							sp_num <= sp_num + 1'b1;
							state <= st_desc;
						end
					end
					st_drain:
					begin
						if (mem_ack)
						begin
							mem_req <= 1'b0;  // close the old handshake, data dropped
							state <= st_desc;
						end
					end
					default: ;  // st_idle
				endcase
			end
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk)
	begin
		if (req_go)
			mem_addr <= desc.base + mem_addr_t'(offs);  // held until ack
		if (data_go)
			word_sr <= mem_data;
		else if (pix_go)
			word_sr <= {word_sr[11:0], 4'h0};  // next pixel to the top
		if (pix_go)
		begin
			buf_x <= x_cur[8:0];
			buf_pix.opaque <= |word_sr[15:12];  // nibble 0 is transparent
			buf_pix.color <= pal_color;         // registered palette lookup
		end
	end

endmodule

// File: source/sprite_tables.sv
`timescale 1ns/1ns

module sprite_tables
	import spr_geom_pkg::*, spr_mem_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	// host side
	input  logic                 tbl_we,
	input  tbl_wr_t              tbl_wr,
	// descriptor read
	input  spr_idx_t             desc_idx,
	output spr_desc_t            desc,
	// palette read
	input  logic [pal_idx_w-1:0] pal_idx,
	output logic [color_w-1:0]   pal_color,
	// row offsets, engine side
	input  logic                 offs_we,
	input  spr_idx_t             offs_idx,
	input  row_offs_t            offs_wd,
	output row_offs_t            offs_rd
);

	localparam int pal_aw = $clog2(pal_entries);

	spr_desc_t          desc_ram [sprite_count];
	logic [color_w-1:0] pal_ram  [pal_entries];
	row_offs_t          offs_ram [sprite_count];
	logic [sprite_count-1:0] desc_act;  // active bits kept apart so reset disables all sprites

	logic     desc_wr, pal_wr;
	spr_idx_t wr_sprite;

	assign desc_wr = tbl_we && (tbl_wr.sel == tbl_sel_desc);
	assign pal_wr = tbl_we && (tbl_wr.sel == tbl_sel_pal);
	assign wr_sprite = tbl_wr.index[4:0];  // 32 descriptors, index[5] ignored

	// --------------------
	// host written storage
	// --------------------
	always_ff @(posedge clk)
	begin
		if (desc_wr)
			desc_ram[wr_sprite] <= spr_desc_t'(tbl_wr.data);
		if (pal_wr)
			pal_ram[tbl_wr.index] <= tbl_wr.data[color_w-1:0];
	end

	// sprite enables and row counters
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			desc_act <= '0;  // nothing fetched until the host sets a sprite up
			for (int i = 0; i < sprite_count; i++)
				offs_ram[i] <= '0;
		end
		else
		begin
			if (desc_wr)
				desc_act[wr_sprite] <= tbl_wr.data[7];  // active bit of the word
			if (offs_we)
				offs_ram[offs_idx] <= offs_wd;  // engine stores the new row offset
		end
	end

	// --------------------
	// combinational reads
	// --------------------
	always_comb
	begin
		desc = desc_ram[desc_idx];
		desc.active = desc_act[desc_idx];
	end

	// banks wrap every four, only pal_bank[1:0] reaches the 64 entries
	assign pal_color = pal_ram[pal_idx[pal_aw-1:0]];
	assign offs_rd = offs_ram[offs_idx];

endmodule

// File: source/sprite_unit.sv
`timescale 1ns/1ns

module sprite_unit
	import spr_geom_pkg::*, spr_mem_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      line_start,
	input  logic      frame_start,
	// host table writes, only while busy is low
	input  logic      tbl_we,
	input  tbl_wr_t   tbl_wr,
	// sprite memory
	output logic      mem_req,
	output mem_addr_t mem_addr,
	input  logic      mem_ack,
	input  mem_word_t mem_data,
	// status and video
	output logic      busy,
	output spr_pix_t  pix,
	output logic      pix_stb
);

	// --------------------
	// engine to tables
	// --------------------
	spr_idx_t             desc_idx;
	spr_desc_t            desc;
	logic [pal_idx_w-1:0] pal_idx;
	logic [color_w-1:0]   pal_color;
	logic                 offs_we;
	spr_idx_t             offs_idx;
	row_offs_t            offs_wd, offs_rd;

	// engine to line buffers
	logic       buf_we;
	spr_coord_t buf_x;
	spr_pix_t   buf_pix;

	sprite_tables i_sprite_tables (
		.clk       (clk),
		.arst_n    (arst_n),
		.tbl_we    (tbl_we),
		.tbl_wr    (tbl_wr),
		.desc_idx  (desc_idx),
		.desc      (desc),
		.pal_idx   (pal_idx),
		.pal_color (pal_color),
		.offs_we   (offs_we),
		.offs_idx  (offs_idx),
		.offs_wd   (offs_wd),
		.offs_rd   (offs_rd)
	);

	sprite_engine i_sprite_engine (
		.clk         (clk),
		.arst_n      (arst_n),
		.line_start  (line_start),
		.frame_start (frame_start),
		.busy        (busy),
		.desc_idx    (desc_idx),
		.desc        (desc),
		.pal_idx     (pal_idx),
		.pal_color   (pal_color),
		.offs_we     (offs_we),
		.offs_idx    (offs_idx),
		.offs_wd     (offs_wd),
		.offs_rd     (offs_rd),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_data    (mem_data),
		.buf_we      (buf_we),
		.buf_x       (buf_x),
		.buf_pix     (buf_pix)
	);

	line_buffers i_line_buffers (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.buf_we     (buf_we),
		.buf_x      (buf_x),
		.buf_pix    (buf_pix),
		.pix        (pix),
		.pix_stb    (pix_stb)
	);

endmodule

// File: sprite_unit.f
source/spr_geom_pkg.sv
source/spr_mem_pkg.sv
source/sprite_tables.sv
source/sprite_engine.sv
source/line_buffers.sv
source/sprite_unit.sv
dv/sprite_unit_chk.sv
dv/sprite_unit_tb.sv
